//--- source/sata_fis_pkg.sv
package sata_fis_pkg;

    // tag carried with every host-to-device dword
    typedef enum logic [1:0] {
        H2D_DATA = 2'd0,  // fis body dword
        H2D_HEAD = 2'd1,  // first dword of a fis
        H2D_LAST = 2'd2   // last dword of a fis
    } h2d_tag_t;

    // tag carried with every device-to-host entry
    typedef enum logic [1:0] {
        D2H_BODY = 2'd0,  // fis body dword
        D2H_HEAD = 2'd1,  // first dword after incoming start
        D2H_OK   = 2'd2,  // end marker for a good fis
        D2H_ERR  = 2'd3   // end marker for an invalidated fis
    } d2h_tag_t;

    typedef logic [31:0] dword_t;  // one sata dword

    // h2d buffer entry, tag on top
    typedef struct packed {
        h2d_tag_t tag;   // entry kind
        dword_t   data;  // payload dword
    } h2d_entry_t;

    // d2h buffer entry, same layout
    typedef struct packed {
        d2h_tag_t tag;   // entry kind, markers carry zero data
        dword_t   data;  // payload dword
    } d2h_entry_t;

endpackage

//--- source/sata_buf_pkg.sv
package sata_buf_pkg;

    localparam int FIFO_ADDR_WIDTH = 9;                     // 512 entries per direction
    localparam int FIFO_DEPTH      = 1 << FIFO_ADDR_WIDTH;  // entries per buffer

    // fill count needs one bit more than the address to reach full
    typedef logic [FIFO_ADDR_WIDTH:0] fill_t;

    localparam int XMIT_START_FILL = 64;   // start frame before last dword is in
    localparam int H2D_READY_LIMIT = 504;  // host stops writing from here on
    localparam int D2H_BUSY_FILL   = 448;  // link is asked to pause from here on
    localparam int D2H_MANY_FILL   = 8;    // host may burst from here on

endpackage

//--- source/fis_fifo.sv
`timescale 1ns/1ps

module fis_fifo #(
    parameter type payload_t = logic [33:0],  // entry type, tag plus dword
    parameter int  MANY_LEVEL = 8             // fill level that raises many
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,    // drop all entries, keeps memory
    input  logic                wr,       // push wr_data
    input  payload_t            wr_data,
    input  logic                rd,       // pop front entry
    output payload_t            rd_data,  // front entry, fall-through
    output logic                nempty,   // rd_data is valid
    output sata_buf_pkg::fill_t fill,     // entries held
    output logic                many      // at least MANY_LEVEL entries
);

    logic [sata_buf_pkg::FIFO_ADDR_WIDTH-1:0] wr_ptr;  // next slot to write
    logic [sata_buf_pkg::FIFO_ADDR_WIDTH-1:0] rd_ptr;  // front slot
    logic                                     full;    // no free slot

    payload_t mem [sata_buf_pkg::FIFO_DEPTH];  // entry storage

    assign full    = fill == sata_buf_pkg::fill_t'(sata_buf_pkg::FIFO_DEPTH);
    assign nempty  = fill != '0;
    assign many    = fill >= sata_buf_pkg::fill_t'(MANY_LEVEL);
    assign rd_data = mem[rd_ptr];  // async read, front entry shows right after write

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wr_data;  // payload only, no reset
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;  // next entry after this edge
            end
        end
    end

    // fill moves on the same edge as the pointers
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            fill <= '0;
        end else begin
            case ({wr, rd})
                2'b10:   fill <= fill + 1'b1;  // push only
                2'b01:   fill <= fill - 1'b1;  // pop only
                default: fill <= fill;         // both or none
            endcase
        end
    end

    // writers upstream gate on fill, so this catches a broken threshold
    a_no_write_full: assert property (
        @(posedge clk) disable iff (rst || flush)
        wr |-> !full
    ) else $error("fis_fifo: write while full");

    // readers gate on nempty, a pop of nothing means a lost handshake
    a_no_read_empty: assert property (
        @(posedge clk) disable iff (rst || flush)
        rd |-> nempty
    ) else $error("fis_fifo: read while empty");

endmodule

//--- source/h2d_frame_scheduler.sv
`timescale 1ns/1ps

module h2d_frame_scheduler (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  h2d_valid,     // host offers an entry
    input  sata_fis_pkg::h2d_tag_t h2d_tag,      // tag of the offered entry
    input  sata_buf_pkg::fill_t   fill,          // h2d buffer fill
    input  logic                  ll_frame_ack,  // link took the frame request
    output logic                  h2d_ready,     // room for one more entry
    output logic                  wr,            // push into h2d buffer
    output logic                  ll_frame_req   // ask link to open a frame
);

    logic pending;      // fis head buffered, frame not yet requested
    logic last_in;      // last dword of the fis accepted now
    logic start_fill;   // enough buffered to start before last dword
    logic req_set;      // conditions met to raise the request

    // registered fill only, never looks at h2d_valid
    assign h2d_ready = fill < sata_buf_pkg::fill_t'(sata_buf_pkg::H2D_READY_LIMIT);
    assign wr        = h2d_valid && h2d_ready;  // accept on valid and ready

    assign last_in    = wr && (h2d_tag == sata_fis_pkg::H2D_LAST);
    assign start_fill = fill >= sata_buf_pkg::fill_t'(sata_buf_pkg::XMIT_START_FILL);
    assign req_set    = pending && (last_in || start_fill);

    always_ff @(posedge clk) begin
        if (rst || ll_frame_req) begin
            pending <= 1'b0;  // cleared once the request is out
        end else if (wr && (h2d_tag == sata_fis_pkg::H2D_HEAD)) begin
            pending <= 1'b1;  // new fis started in the buffer
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ll_frame_req <= 1'b0;
        end else if (ll_frame_req && ll_frame_ack) begin
            ll_frame_req <= 1'b0;  // drop on the edge after ack
        end else if (req_set) begin
            ll_frame_req <= 1'b1;  // whole fis in, or start threshold hit
        end
    end

    // request is held for the link, only an ack may take it down
    a_req_held_until_ack: assert property (
        @(posedge clk) disable iff (rst)
        ll_frame_req && !ll_frame_ack |=> ll_frame_req
    ) else $error("h2d_frame_scheduler: frame request dropped without ack");

endmodule

//--- source/d2h_fis_tagger.sv
`timescale 1ns/1ps

module d2h_fis_tagger (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      ll_rx_valid,          // link pushes a dword
    input  sata_fis_pkg::dword_t      ll_rx_data,
    input  logic                      ll_incom_start,       // pulse, new fis begins
    input  logic                      ll_incom_done,        // pulse, fis ended good
    input  logic                      ll_incom_invalidate,  // pulse, fis ended bad
    input  sata_buf_pkg::fill_t       fill,                 // d2h buffer fill
    output logic                      wr,                   // push into d2h buffer
    output sata_fis_pkg::d2h_entry_t  wr_data,
    output logic                      ll_rx_busy            // ask link to pause
);

    sata_fis_pkg::d2h_tag_t cur_tag;   // tag for the next pushed entry
    logic                   inval_r;   // invalidate one cycle late
    logic                   fis_end;   // end event seen this cycle
    logic                   fis_over;  // push end marker now

    // invalidate is delayed so the last dword of a bad fis still passes
    assign fis_end = ll_incom_done || inval_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            inval_r <= 1'b0;
        end else begin
            inval_r <= ll_incom_invalidate;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || ll_incom_start) begin
            cur_tag <= sata_fis_pkg::D2H_HEAD;  // first dword is the head
        end else if (ll_rx_valid) begin
            cur_tag <= sata_fis_pkg::D2H_BODY;  // everything after head
        end else if (fis_end) begin
            cur_tag <= inval_r ? sata_fis_pkg::D2H_ERR : sata_fis_pkg::D2H_OK;
        end
    end

    // marker only after body, tag leaves BODY so this fires once per fis
    always_ff @(posedge clk) begin
        if (rst) begin
            fis_over <= 1'b0;
        end else begin
            fis_over <= fis_end && (cur_tag == sata_fis_pkg::D2H_BODY);
        end
    end

    assign wr           = ll_rx_valid || fis_over;  // one stream into the buffer
    assign wr_data.tag  = cur_tag;                  // OK or ERR on the marker
    assign wr_data.data = fis_over ? '0 : ll_rx_data;

    // pause the link early, it still has dwords in flight
    assign ll_rx_busy = fill >= sata_buf_pkg::fill_t'(sata_buf_pkg::D2H_BUSY_FILL);

    // link is quiet on the cycle the marker goes in
    a_marker_no_collision: assert property (
        @(posedge clk) disable iff (rst)
        fis_over |-> !ll_rx_valid
    ) else $error("d2h_fis_tagger: link dword collides with end marker");

    // end marker carries a result tag, never head or body
    a_marker_tag: assert property (
        @(posedge clk) disable iff (rst)
        fis_over |-> cur_tag inside {sata_fis_pkg::D2H_OK, sata_fis_pkg::D2H_ERR}
    ) else $error("d2h_fis_tagger: end marker without result tag");

endmodule

//--- source/sata_transport_buffers.sv
`timescale 1ns/1ps

module sata_transport_buffers (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   st_cleared,         // software stop, flush both buffers

    input  sata_fis_pkg::dword_t   h2d_data,           // host to device entry
    input  sata_fis_pkg::h2d_tag_t h2d_tag,
    input  logic                   h2d_valid,
    output logic                   h2d_ready,

    output sata_fis_pkg::dword_t   ll_tx_data,         // front h2d entry to link
    output logic                   ll_tx_last,         // front entry ends the fis
    output logic                   ll_tx_valid,
    input  logic                   ll_tx_strobe,       // link consumes front entry

    output logic                   ll_frame_req,       // open an outgoing frame
    input  logic                   ll_frame_ack,

    input  sata_fis_pkg::dword_t   ll_rx_data,         // incoming dword from link
    input  logic                   ll_rx_valid,
    input  logic                   ll_incom_start,
    input  logic                   ll_incom_done,
    input  logic                   ll_incom_invalidate,
    output logic                   ll_rx_busy,         // d2h buffer almost full

    output sata_fis_pkg::dword_t   d2h_data,           // device to host entry
    output sata_fis_pkg::d2h_tag_t d2h_tag,
    output logic                   d2h_valid,
    output logic                   d2h_many,           // host may burst
    input  logic                   d2h_ready
);

    logic                     h2d_wr;       // host entry accepted
    logic                     h2d_rd;       // link took front entry
    sata_fis_pkg::h2d_entry_t h2d_wr_data;
    sata_fis_pkg::h2d_entry_t h2d_rd_data;
    sata_buf_pkg::fill_t      h2d_fill;

    logic                     d2h_wr;       // tagged link dword or marker
    logic                     d2h_rd;       // host took front entry
    sata_fis_pkg::d2h_entry_t d2h_wr_data;
    sata_fis_pkg::d2h_entry_t d2h_rd_data;
    sata_buf_pkg::fill_t      d2h_fill;

    assign h2d_wr_data.tag  = h2d_tag;
    assign h2d_wr_data.data = h2d_data;
    assign h2d_rd           = ll_tx_valid && ll_tx_strobe;
    assign ll_tx_data       = h2d_rd_data.data;
    assign ll_tx_last       = h2d_rd_data.tag == sata_fis_pkg::H2D_LAST;

    assign d2h_rd   = d2h_valid && d2h_ready;
    assign d2h_data = d2h_rd_data.data;
    assign d2h_tag  = d2h_rd_data.tag;

    h2d_frame_scheduler u_h2d_sched (
        .clk          (clk),
        .rst          (rst),
        .h2d_valid    (h2d_valid),
        .h2d_tag      (h2d_tag),
        .fill         (h2d_fill),
        .ll_frame_ack (ll_frame_ack),
        .h2d_ready    (h2d_ready),
        .wr           (h2d_wr),
        .ll_frame_req (ll_frame_req)
    );

    fis_fifo #(
        .payload_t  (sata_fis_pkg::h2d_entry_t),
        .MANY_LEVEL (sata_buf_pkg::XMIT_START_FILL)  // many unused on this side
    ) h2d_fifo (
        .clk     (clk),
        .rst     (rst),
        .flush   (st_cleared),
        .wr      (h2d_wr),
        .wr_data (h2d_wr_data),
        .rd      (h2d_rd),
        .rd_data (h2d_rd_data),
        .nempty  (ll_tx_valid),  // valid one cycle after host accept
        .fill    (h2d_fill),
        .many    ()
    );

    d2h_fis_tagger u_d2h_tagger (
        .clk                 (clk),
        .rst                 (rst),
        .ll_rx_valid         (ll_rx_valid),
        .ll_rx_data          (ll_rx_data),
        .ll_incom_start      (ll_incom_start),
        .ll_incom_done       (ll_incom_done),
        .ll_incom_invalidate (ll_incom_invalidate),
        .fill                (d2h_fill),
        .wr                  (d2h_wr),
        .wr_data             (d2h_wr_data),
        .ll_rx_busy          (ll_rx_busy)
    );

    fis_fifo #(
        .payload_t  (sata_fis_pkg::d2h_entry_t),
        .MANY_LEVEL (sata_buf_pkg::D2H_MANY_FILL)
    ) d2h_fifo (
        .clk     (clk),
        .rst     (rst),
        .flush   (st_cleared),
        .wr      (d2h_wr),
        .wr_data (d2h_wr_data),
        .rd      (d2h_rd),
        .rd_data (d2h_rd_data),
        .nempty  (d2h_valid),  // valid one cycle after link push
        .fill    (d2h_fill),
        .many    (d2h_many)
    );

endmodule

//--- dv/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

int checks;      // compares done
int errors;      // compares failed
int test_base;   // errors before the running test

sata_fis_pkg::h2d_entry_t h2d_q[$];  // accepted host entries, link order
sata_fis_pkg::d2h_entry_t d2h_q[$];  // expected entries toward the host

task automatic check_h2d(input string name, input sata_fis_pkg::h2d_entry_t exp,
                         input sata_fis_pkg::h2d_entry_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
    end
endtask

task automatic check_d2h(input string name, input sata_fis_pkg::d2h_entry_t exp,
                         input sata_fis_pkg::d2h_entry_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
    end
endtask

task automatic check_fill(input string name, input sata_buf_pkg::fill_t exp,
                          input sata_buf_pkg::fill_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("Error at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("Error at %0t ns: %s expected %b got %b", $time, name, exp, act);
    end
endtask

`endif

//--- dv/tb_sata_transport_buffers.sv
`timescale 1ns/1ps

module tb_sata_transport_buffers;

    localparam int TIMEOUT = 5000;  // cycles per wait loop

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   st_cleared;
    sata_fis_pkg::dword_t   h2d_data;
    sata_fis_pkg::h2d_tag_t h2d_tag;
    logic                   h2d_valid;
    logic                   h2d_ready;
    sata_fis_pkg::dword_t   ll_tx_data;
    logic                   ll_tx_last;
    logic                   ll_tx_valid;
    logic                   ll_tx_strobe;
    logic                   ll_frame_req;
    logic                   ll_frame_ack;
    sata_fis_pkg::dword_t   ll_rx_data;
    logic                   ll_rx_valid;
    logic                   ll_incom_start;
    logic                   ll_incom_done;
    logic                   ll_incom_invalidate;
    logic                   ll_rx_busy;
    sata_fis_pkg::dword_t   d2h_data;
    sata_fis_pkg::d2h_tag_t d2h_tag;
    logic                   d2h_valid;
    logic                   d2h_many;
    logic                   d2h_ready;

    logic [31:0] seq_rng = 32'd37;  // sequence rng
    logic [31:0] bg_rng  = 32'd37;  // link and host agent rng
    int          strobe_mode;       // 0 low, 1 high, 2 random
    int          ready_mode;        // same for d2h_ready
    logic        auto_ack;          // link acks requests by itself
    logic        req_seen;          // ll_frame_req at last negedge
    int          rise_fill;         // h2d entries held when request rose
    logic        in_head;           // next link dword is the head
    int          mark_dly;          // cycles until the end marker goes in
    sata_fis_pkg::d2h_tag_t mark_tag;

    `include "tb_model.svh"

    sata_transport_buffers uut (.*);

    always #10 clk = ~clk;  // 20 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        seq_rng = xorshift32(seq_rng);
        return seq_rng;
    endfunction

    // link and host agents, random or fixed patterns
    always @(posedge clk) begin
        bg_rng = xorshift32(bg_rng);
        ll_tx_strobe <= (strobe_mode == 2) ? bg_rng[0] : (strobe_mode == 1);
        d2h_ready    <= (ready_mode == 2) ? bg_rng[7] : (ready_mode == 1);
        if (auto_ack) begin
            ll_frame_ack <= req_seen && !ll_frame_ack;  // one-cycle ack
        end
    end

    // reference model, sampled mid-cycle where everything is settled
    always @(negedge clk) begin : monitor
        sata_fis_pkg::h2d_entry_t exp_h;
        sata_fis_pkg::h2d_entry_t act_h;
        sata_fis_pkg::d2h_entry_t exp_d;
        if (!rst) begin
            if (ll_frame_req && !req_seen) rise_fill = h2d_q.size();
            req_seen = ll_frame_req;
            check_fill("h2d_fill", sata_buf_pkg::fill_t'(h2d_q.size()), uut.h2d_fill);
            check_fill("d2h_fill", sata_buf_pkg::fill_t'(d2h_q.size()), uut.d2h_fill);
            check_flag("h2d_ready", h2d_q.size() < sata_buf_pkg::H2D_READY_LIMIT, h2d_ready);
            check_flag("ll_tx_valid", h2d_q.size() != 0, ll_tx_valid);
            check_flag("d2h_valid", d2h_q.size() != 0, d2h_valid);
            check_flag("d2h_many", d2h_q.size() >= sata_buf_pkg::D2H_MANY_FILL, d2h_many);
            check_flag("ll_rx_busy", d2h_q.size() >= sata_buf_pkg::D2H_BUSY_FILL, ll_rx_busy);
            if (st_cleared) begin
                h2d_q.delete();  // flush wins over any handshake
                d2h_q.delete();
                mark_dly = 0;
            end else begin
                if (ll_tx_valid && ll_tx_strobe && h2d_q.size() != 0) begin
                    exp_h = h2d_q.pop_front();
                    if (exp_h.tag != sata_fis_pkg::H2D_LAST) exp_h.tag = sata_fis_pkg::H2D_DATA;
                    act_h.data = ll_tx_data;
                    act_h.tag  = ll_tx_last ? sata_fis_pkg::H2D_LAST : sata_fis_pkg::H2D_DATA;
                    check_h2d("ll_tx", exp_h, act_h);
                end
                if (h2d_valid && h2d_ready) h2d_q.push_back({h2d_tag, h2d_data});
                if (d2h_valid && d2h_ready && d2h_q.size() != 0) begin
                    exp_d = d2h_q.pop_front();
                    check_d2h("d2h", exp_d, {d2h_tag, d2h_data});
                end
                if (mark_dly > 0) begin
                    mark_dly--;
                    if (mark_dly == 0) d2h_q.push_back({mark_tag, 32'd0});  // zero-data marker
                end
                if (ll_rx_valid) begin
                    d2h_q.push_back({in_head ? sata_fis_pkg::D2H_HEAD : sata_fis_pkg::D2H_BODY,
                                     ll_rx_data});
                    in_head = 1'b0;
                end
                if (ll_incom_start) in_head = 1'b1;
                if (ll_incom_done) begin
                    mark_dly = 1;  // marker one cycle after done
                    mark_tag = sata_fis_pkg::D2H_OK;
                end
                if (ll_incom_invalidate) begin
                    mark_dly = 2;  // invalidate is seen a cycle late
                    mark_tag = sata_fis_pkg::D2H_ERR;
                end
            end
        end
    end

    task automatic timeout_abort(input string what);
        $display("timeout while waiting for %s", what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic host_write(input sata_fis_pkg::h2d_tag_t tag, input logic [31:0] data);
        int t;
        t = 0;
        h2d_valid <= 1'b1;
        h2d_tag   <= tag;
        h2d_data  <= data;
        @(negedge clk);
        while (!h2d_ready) begin  // accepted on the next edge once ready
            t++;
            if (t > TIMEOUT) timeout_abort("h2d_ready");
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic host_fis(input int len, input logic with_last);
        host_write(sata_fis_pkg::H2D_HEAD, next_rand());
        for (int i = 0; i < len - 2; i++) host_write(sata_fis_pkg::H2D_DATA, next_rand());
        if (with_last) host_write(sata_fis_pkg::H2D_LAST, next_rand());
        h2d_valid <= 1'b0;
        @(posedge clk);
    endtask

    task automatic link_fis(input int len, input logic bad);
        ll_incom_start <= 1'b1;
        @(posedge clk);
        ll_incom_start <= 1'b0;
        for (int i = 0; i < len; i++) begin
            ll_rx_valid <= 1'b1;
            ll_rx_data  <= next_rand();
            @(posedge clk);
        end
        ll_rx_valid         <= 1'b0;
        ll_incom_done       <= !bad;
        ll_incom_invalidate <= bad;
        @(posedge clk);
        ll_incom_done       <= 1'b0;
        ll_incom_invalidate <= 1'b0;
        repeat (3) @(posedge clk);  // room for the marker
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        @(negedge clk);
        while (h2d_q.size() != 0 || d2h_q.size() != 0 || mark_dly != 0 || ll_frame_req) begin
            t++;
            if (t > TIMEOUT) timeout_abort("buffers to drain");
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic wait_req(input logic level);
        int t;
        t = 0;
        @(negedge clk);
        while (ll_frame_req !== level) begin
            t++;
            if (t > TIMEOUT) timeout_abort("ll_frame_req");
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic ack_once();
        ll_frame_ack <= 1'b1;
        @(posedge clk);
        ll_frame_ack <= 1'b0;
        @(negedge clk);
        check_flag("ll_frame_req after ack", 1'b0, ll_frame_req);
        @(posedge clk);
    endtask

    task automatic report_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    initial begin
        rst <= 1'b1;
        st_cleared <= 1'b0;
        h2d_valid <= 1'b0;
        h2d_tag <= sata_fis_pkg::H2D_DATA;
        h2d_data <= '0;
        ll_tx_strobe <= 1'b0;
        ll_frame_ack <= 1'b0;
        ll_rx_data <= '0;
        ll_rx_valid <= 1'b0;
        ll_incom_start <= 1'b0;
        ll_incom_done <= 1'b0;
        ll_incom_invalidate <= 1'b0;
        d2h_ready <= 1'b0;
        strobe_mode = 2;
        ready_mode = 2;
        auto_ack = 1'b1;
        req_seen = 1'b0;
        in_head = 1'b0;
        mark_dly = 0;
        repeat (2) @(posedge clk);  // reset for 2 cycles
        rst <= 1'b0;
        @(posedge clk);

        for (int i = 0; i < 8; i++) host_fis(2 + next_rand() % 19, 1'b1);
        wait_drained();
        report_test("h2d_order");

        auto_ack = 1'b0;
        strobe_mode = 0;
        host_fis(5, 1'b0);  // head and data, no last yet
        repeat (4) @(posedge clk);
        check_flag("ll_frame_req before last", 1'b0, ll_frame_req);
        host_write(sata_fis_pkg::H2D_LAST, next_rand());
        h2d_valid <= 1'b0;
        wait_req(1'b1);
        repeat (3) @(posedge clk);
        check_flag("ll_frame_req held", 1'b1, ll_frame_req);
        ack_once();
        host_fis(72, 1'b0);  // long fis, request on threshold
        wait_req(1'b1);
        checks++;
        if (rise_fill < sata_buf_pkg::XMIT_START_FILL ||
            rise_fill > sata_buf_pkg::XMIT_START_FILL + 2) begin
            errors++;
            $display("frame request rose with %0d entries buffered, not at the start threshold",
                     rise_fill);
        end
        ack_once();
        host_write(sata_fis_pkg::H2D_LAST, next_rand());
        h2d_valid <= 1'b0;
        strobe_mode = 1;
        auto_ack = 1'b1;
        wait_drained();
        report_test("frame_req");

        strobe_mode = 0;
        host_fis(sata_buf_pkg::H2D_READY_LIMIT + 1, 1'b0);  // stalls on h2d_ready
        check_fill("h2d fill at limit", sata_buf_pkg::H2D_READY_LIMIT, uut.h2d_fill);
        check_flag("h2d_ready at limit", 1'b0, h2d_ready);
        strobe_mode = 2;
        host_write(sata_fis_pkg::H2D_LAST, next_rand());
        h2d_valid <= 1'b0;
        wait_drained();
        report_test("h2d_backpressure");

        for (int i = 0; i < 6; i++) link_fis(2 + next_rand() % 39, i[0]);
        wait_drained();
        report_test("d2h_tagging");

        ready_mode = 0;
        link_fis(460, 1'b0);  // many and busy checked each cycle
        check_flag("ll_rx_busy held", 1'b1, ll_rx_busy);
        ready_mode = 1;
        wait_drained();
        report_test("d2h_flags");

        strobe_mode = 0;
        ready_mode = 0;
        host_fis(10, 1'b1);
        link_fis(10, 1'b0);
        st_cleared <= 1'b1;
        @(posedge clk);
        st_cleared <= 1'b0;
        @(negedge clk);
        check_flag("ll_tx_valid after flush", 1'b0, ll_tx_valid);
        check_flag("d2h_valid after flush", 1'b0, d2h_valid);
        strobe_mode = 2;
        ready_mode = 2;
        wait_drained();
        report_test("flush");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+dv
source/sata_fis_pkg.sv
source/sata_buf_pkg.sv
source/fis_fifo.sv
source/h2d_frame_scheduler.sv
source/d2h_fis_tagger.sv
source/sata_transport_buffers.sv
dv/tb_sata_transport_buffers.sv

//--- Bender.yml
package:
  name: sata_transport_buffers

sources:
  - files:
      - source/sata_fis_pkg.sv
      - source/sata_buf_pkg.sv
      - source/fis_fifo.sv
      - source/h2d_frame_scheduler.sv
      - source/d2h_fis_tagger.sv
      - source/sata_transport_buffers.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_sata_transport_buffers.sv
